// ==== design/reflet_exti.sv ====
`timescale 1ns/10ps
`default_nettype none

module reflet_exti #(
    parameter int base_addr_size = 16,
    parameter logic [base_addr_size-1:0] base_addr = 16'hFF0C
) (
    input  wire logic                              clk,
    input  wire logic                              rst,
    // chip-select strobe from the system bus
    input  wire logic                              enable,
    input  wire logic [base_addr_size-1:0]         addr,
    input  wire reflet_pkg::bus_req_t              req,
    // raw pulses from the peripherals
    input  wire reflet_pkg::int_src_t              int_in,
    output logic      [reflet_pkg::DATA_W-1:0]     data_out,
    output logic      [reflet_pkg::NUM_CPU_INT-1:0] cpu_int
);

    import reflet_pkg::*;

    // enable, level and status
    localparam int NUM_REGS = 3;

    logic [base_addr_size-1:0] addr_delta;
    logic                      in_window;
    logic                      sel;
    logic [OFFSET_W-1:0]       offset;

    logic [DATA_W-1:0]         dout_enable;
    logic [DATA_W-1:0]         dout_level;
    logic [DATA_W-1:0]         dout_status;

    int_src_t                  int_en;
    int_level_t                int_level;
    int_src_t                  status;

    // window decode
    // subtract first so base_addr + 2 near the top of the map cannot wrap
    assign addr_delta = addr - base_addr;
    assign in_window  = (addr >= base_addr) && (addr_delta < NUM_REGS);
    assign sel        = enable && in_window;
    assign offset     = addr_delta[OFFSET_W-1:0];

    // enable mask, one bit per source
    reflet_rw_register #(
        .reg_t         (int_src_t),
        .reg_addr      (REG_ENABLE),
        .default_value ('0)
    ) i_reg_enable (
        .clk      (clk),
        .rst      (rst),
        .sel      (sel),
        .offset   (offset),
        .req      (req),
        .data_out (dout_enable),
        .value    (int_en)
    );

    // level register, 2 bits of line number per source
    reflet_rw_register #(
        .reg_t         (int_level_t),
        .reg_addr      (REG_LEVEL),
        .default_value ('0)
    ) i_reg_level (
        .clk      (clk),
        .rst      (rst),
        .sel      (sel),
        .offset   (offset),
        .req      (req),
        .data_out (dout_level),
        .value    (int_level)
    );

    // sticky status
    // pulses set bits, software writes zeros to clear
    reflet_rwe_register #(
        .reg_addr      (REG_STATUS),
        .default_value ('0)
    ) i_reg_status (
        .clk      (clk),
        .rst      (rst),
        .sel      (sel),
        .offset   (offset),
        .req      (req),
        .set      (int_in),
        .data_out (dout_status),
        .value    (status)
    );

    // mask and route pending sources onto the cpu lines
    reflet_int_router i_router (
        .status    (status),
        .int_en    (int_en),
        .int_level (int_level),
        .cpu_int   (cpu_int)
    );

    // each slice is zero unless its register is addressed
    assign data_out = dout_enable | dout_level | dout_status;

endmodule

`default_nettype wire

// ==== design/reflet_int_router.sv ====
`timescale 1ns/10ps
`default_nettype none

module reflet_int_router (
    // latched pending sources
    input  wire reflet_pkg::int_src_t                  status,
    // software mask, 1 lets the source through
    input  wire reflet_pkg::int_src_t                  int_en,
    // cpu line chosen for each source
    input  wire reflet_pkg::int_level_t                int_level,
    output logic [reflet_pkg::NUM_CPU_INT-1:0]         cpu_int
);

    import reflet_pkg::*;

    logic [NUM_SRC-1:0]          active;
    logic [NUM_SRC-1:0][1:0]     level_vec;
    logic [NUM_CPU_INT-1:0]      line_sel [NUM_SRC];

    // pending and enabled
    assign active = status & int_en;

    // same source order as int_src_t, gpio at index 0
    assign level_vec = {
        int_level.timer_2_level,
        int_level.timer_level,
        int_level.uart_level,
        int_level.gpio_level
    };

    // per source: level decoded to one-hot, gated by active
    for (genvar i = 0; i < NUM_SRC; i++) begin : g_src
        assign line_sel[i] = active[i] ? (NUM_CPU_INT'(1) << level_vec[i]) : '0;
    end

    // several sources may share one line
    always_comb begin
        cpu_int = '0;
        for (int i = 0; i < NUM_SRC; i++) begin
            cpu_int = cpu_int | line_sel[i];
        end
    end

endmodule

`default_nettype wire

// ==== design/reflet_pkg.sv ====
`default_nettype none

package reflet_pkg;

    // width of one system bus data word
    localparam int DATA_W = 8;

    // peripheral interrupt sources: gpio, uart, timer, timer_2
    localparam int NUM_SRC = 4;

    // interrupt lines going into the cpu
    localparam int NUM_CPU_INT = 4;

    // register offset inside the exti window
    localparam int OFFSET_W = 2;

    // register map, relative to base_addr
    localparam logic [OFFSET_W-1:0] REG_ENABLE = 2'd0;
    localparam logic [OFFSET_W-1:0] REG_LEVEL  = 2'd1;
    localparam logic [OFFSET_W-1:0] REG_STATUS = 2'd2;

    // one bit per source, gpio in bit 0
    // shared by the raw pulses, the enable mask and the sticky status
    typedef struct packed {
        logic timer_2;
        logic timer;
        logic uart;
        logic gpio;
    } int_src_t;

    // 2-bit cpu line number per source, gpio in bits 1:0
    typedef struct packed {
        logic [1:0] timer_2_level;
        logic [1:0] timer_level;
        logic [1:0] uart_level;
        logic [1:0] gpio_level;
    } int_level_t;

    // what the bus presents in one cycle, besides enable and addr
    // address width depends on the top parameter so it travels on its own
    typedef struct packed {
        logic              write_en;
        logic [DATA_W-1:0] data_in;
    } bus_req_t;

endpackage

`default_nettype wire

// ==== design/reflet_rw_register.sv ====
`timescale 1ns/10ps
`default_nettype none

module reflet_rw_register #(
    parameter type reg_t = reflet_pkg::int_src_t,
    parameter logic [reflet_pkg::OFFSET_W-1:0] reg_addr = reflet_pkg::REG_ENABLE,
    parameter reg_t default_value = '0
) (
    input  wire logic                              clk,
    input  wire logic                              rst,
    // high while the access falls inside the exti window
    input  wire logic                              sel,
    input  wire logic [reflet_pkg::OFFSET_W-1:0]   offset,
    input  wire reflet_pkg::bus_req_t              req,
    output logic      [reflet_pkg::DATA_W-1:0]     data_out,
    output reg_t                                   value
);

    import reflet_pkg::*;

    // payload width, at most one bus word
    localparam int PAY_W = $bits(reg_t);

    logic hit;
    logic wr_hit;

    // this register is the one being addressed
    assign hit    = sel && (offset == reg_addr);
    assign wr_hit = hit && req.write_en;

    // only the low PAY_W bits of the bus word land in the payload
    always_ff @(posedge clk) begin
        if (rst) begin
            value <= default_value;
        end else if (wr_hit) begin
            value <= reg_t'(req.data_in[PAY_W-1:0]);
        end
    end

    // combinational read
    // unused upper bits and unaddressed cycles give zero so the top can OR slices
    always_comb begin
        data_out = '0;
        if (hit) begin
            data_out[PAY_W-1:0] = value;
        end
    end

endmodule

`default_nettype wire

// ==== design/reflet_rwe_register.sv ====
`timescale 1ns/10ps
`default_nettype none

module reflet_rwe_register #(
    parameter logic [reflet_pkg::OFFSET_W-1:0] reg_addr = reflet_pkg::REG_STATUS,
    parameter reflet_pkg::int_src_t default_value = '0
) (
    input  wire logic                              clk,
    input  wire logic                              rst,
    input  wire logic                              sel,
    input  wire logic [reflet_pkg::OFFSET_W-1:0]   offset,
    input  wire reflet_pkg::bus_req_t              req,
    // hardware set request, one bit per source
    input  wire reflet_pkg::int_src_t              set,
    output logic      [reflet_pkg::DATA_W-1:0]     data_out,
    output reflet_pkg::int_src_t                   value
);

    import reflet_pkg::*;

    logic hit;
    logic wr_hit;
    logic set_any;

    assign hit     = sel && (offset == reg_addr);
    assign wr_hit  = hit && req.write_en;
    // any pending pulse overrides the bus
    assign set_any = |set;

    always_ff @(posedge clk) begin
        if (rst) begin
            value <= default_value;
        end else if (set_any) begin
            // sticky: bits only accumulate here
            // a bus write in the same cycle is dropped
            value <= int_src_t'(value | set);
        end else if (wr_hit) begin
            // software clears bits by writing zeros
            value <= int_src_t'(req.data_in[NUM_SRC-1:0]);
        end
    end

    // read path
    // bits above NUM_SRC stay at zero
    always_comb begin
        data_out = '0;
        if (hit) begin
            data_out[NUM_SRC-1:0] = value;
        end
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --timescale 1ns/10ps -j 0 \
    --top-module reflet_exti_tb -f sources.f

run_status=0
./obj_dir/Vreflet_exti_tb > sim.log 2>&1 || run_status=$?
cat sim.log

if grep -q "TB FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
if [ "$run_status" -ne 0 ]; then
    echo "simulator exited with status $run_status"
    exit 1
fi
echo "simulation finished without failure"

// ==== sim/reflet_exti_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module reflet_exti_checker #(
    parameter int base_addr_size = 16,
    parameter logic [base_addr_size-1:0] base_addr = 16'hFF0C
) (
    input  wire logic                                clk,
    input  wire logic                                rst,
    input  wire logic                                enable,
    input  wire logic [base_addr_size-1:0]           addr,
    input  wire reflet_pkg::bus_req_t                req,
    input  wire reflet_pkg::int_src_t                int_in,
    input  wire logic [reflet_pkg::DATA_W-1:0]       data_out,
    input  wire logic [reflet_pkg::NUM_CPU_INT-1:0]  cpu_int,
    // current test, only for the error lines
    input  wire logic [3:0]                          test_num,
    output int                                       err_count
);

    import reflet_pkg::*;

    int          errs = 0;

    // model of the three registers
    int_src_t    m_en;
    int_level_t  m_lvl;
    int_src_t    m_status;

    logic [31:0] addr_ext;
    logic [31:0] base_ext;
    logic [31:0] delta;
    logic        sel;
    logic [1:0]  off;

    assign err_count = errs;

    // window decode done in 32 bits so base + 2 never wraps
    assign addr_ext = 32'(addr);
    assign base_ext = 32'(base_addr);
    assign delta    = addr_ext - base_ext;
    assign sel      = enable && (addr_ext >= base_ext) && (delta <= 32'd2);
    assign off      = delta[1:0];

    function automatic string test_name(input logic [3:0] n);
        case (n)
            4'd1:    return "reset_values";
            4'd2:    return "register_readback";
            4'd3:    return "sticky_status";
            4'd4:    return "interrupt_routing";
            4'd5:    return "outside_window";
            default: return "idle";
        endcase
    endfunction

    // pending and enabled sources raise the line named by their level
    function automatic logic [NUM_CPU_INT-1:0] expected_cpu_int(input int_src_t st,
                                                                input int_src_t en,
                                                                input int_level_t lvl);
        logic [NUM_SRC-1:0]     act;
        logic [2*NUM_SRC-1:0]   lv;
        logic [NUM_CPU_INT-1:0] res;
        act = st & en;
        lv  = lvl;
        res = '0;
        for (int i = 0; i < NUM_SRC; i++) begin
            if (act[i]) begin
                res[lv[2*i +: 2]] = 1'b1;
            end
        end
        return res;
    endfunction

    // zero outside the window, upper bits of 4-bit registers read zero
    function automatic logic [DATA_W-1:0] expected_read(input logic hit, input logic [1:0] o,
                                                        input int_src_t en, input int_level_t lvl,
                                                        input int_src_t st);
        if (!hit) begin
            return '0;
        end
        case (o)
            REG_ENABLE: return DATA_W'(en);
            REG_LEVEL:  return lvl;
            REG_STATUS: return DATA_W'(st);
            default:    return '0;
        endcase
    endfunction

    always @(posedge clk) begin
        logic [NUM_CPU_INT-1:0] exp_int;
        logic [DATA_W-1:0]      exp_rd;
        // compare against the model state before this edge
        if (!rst) begin
            exp_int = expected_cpu_int(m_status, m_en, m_lvl);
            if (cpu_int !== exp_int) begin
                $display("ERROR %s: cpu_int expected %h actual %h",
                         test_name(test_num), exp_int, cpu_int);
                errs++;
            end
            if (!req.write_en) begin
                exp_rd = expected_read(sel, off, m_en, m_lvl, m_status);
                if (data_out !== exp_rd) begin
                    $display("ERROR %s: data_out expected %h actual %h",
                             test_name(test_num), exp_rd, data_out);
                    errs++;
                end
            end
        end
        // then advance the model
        if (rst) begin
            m_en     <= '0;
            m_lvl    <= '0;
            m_status <= '0;
        end else begin
            // a pulse beats a clearing write
            if (int_in != '0) begin
                m_status <= int_src_t'(m_status | int_in);
            end else if (sel && req.write_en && (off == REG_STATUS)) begin
                m_status <= int_src_t'(req.data_in[NUM_SRC-1:0]);
            end
            if (sel && req.write_en && (off == REG_ENABLE)) begin
                m_en <= int_src_t'(req.data_in[NUM_SRC-1:0]);
            end
            if (sel && req.write_en && (off == REG_LEVEL)) begin
                m_lvl <= int_level_t'(req.data_in);
            end
        end
    end

endmodule

`default_nettype wire

// ==== sim/reflet_exti_sva.sv ====
`timescale 1ns/10ps
`default_nettype none

module reflet_exti_sva (
    input  wire logic                                clk,
    input  wire logic                                rst,
    input  wire logic                                sel,
    input  wire reflet_pkg::int_src_t                status,
    input  wire logic [reflet_pkg::DATA_W-1:0]       data_out,
    input  wire logic [reflet_pkg::NUM_CPU_INT-1:0]  cpu_int
);

    import reflet_pkg::*;

    // failure counts, read by the testbench top
    int reset_fails = 0;
    int status_fails = 0;
    int window_fails = 0;

    // lines quiet once reset has been seen on two edges
    a_reset_quiet: assert property (@(posedge clk) rst && $past(rst) |-> cpu_int == '0)
        else begin
            $error("cpu_int active while rst is held");
            reset_fails++;
        end

    // a raised line needs a pending source
    a_int_has_status: assert property (@(posedge clk) disable iff (rst)
        cpu_int != '0 |-> status != '0)
        else begin
            $error("cpu_int raised with status clear");
            status_fails++;
        end

    // no read data outside the window or with the strobe low
    a_window_quiet: assert property (@(posedge clk) disable iff (rst)
        !sel |-> data_out == '0)
        else begin
            $error("data_out driven outside the address window");
            window_fails++;
        end

endmodule

bind reflet_exti reflet_exti_sva i_sva (
    .clk      (clk),
    .rst      (rst),
    .sel      (sel),
    .status   (status),
    .data_out (data_out),
    .cpu_int  (cpu_int)
);

`default_nettype wire

// ==== sim/reflet_exti_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module reflet_exti_tb;

    import reflet_pkg::*;

    localparam int ADDR_W = 16;
    localparam logic [ADDR_W-1:0] BASE = 16'hFF0C;
    localparam int RESET_CYCLES = 4;
    // cycles allowed for a pulse to show up in status
    localparam int WAIT_LIMIT = 8;
    localparam int NUM_TESTS = 5;

    logic                   clk;
    logic                   rst;
    logic                   enable;
    logic [ADDR_W-1:0]      addr;
    bus_req_t               req;
    int_src_t               int_in;
    logic [DATA_W-1:0]      data_out;
    logic [NUM_CPU_INT-1:0] cpu_int;

    logic [3:0]             test_num;
    int                     err_count;
    int                     timeouts;
    int                     fails_before;
    int                     total_fails;
    logic [31:0]            lfsr;
    string                  label;

    // 100 ns clock
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    reflet_exti #(
        .base_addr_size (ADDR_W),
        .base_addr      (BASE)
    ) i_dut (
        .clk      (clk),
        .rst      (rst),
        .enable   (enable),
        .addr     (addr),
        .req      (req),
        .int_in   (int_in),
        .data_out (data_out),
        .cpu_int  (cpu_int)
    );

    reflet_exti_checker #(
        .base_addr_size (ADDR_W),
        .base_addr      (BASE)
    ) i_checker (
        .clk       (clk),
        .rst       (rst),
        .enable    (enable),
        .addr      (addr),
        .req       (req),
        .int_in    (int_in),
        .data_out  (data_out),
        .cpu_int   (cpu_int),
        .test_num  (test_num),
        .err_count (err_count)
    );

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit, bits land lsb first from the right
    task automatic rand_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[6:0], lfsr[0]};
        end
    endtask

    // all inputs change on the falling edge
    task automatic drive(input logic en, input logic [ADDR_W-1:0] a, input logic we,
                         input logic [DATA_W-1:0] d, input int_src_t pulse_in);
        @(negedge clk);
        enable       = en;
        addr         = a;
        req.write_en = we;
        req.data_in  = d;
        int_in       = pulse_in;
    endtask

    task automatic idle(input int n);
        repeat (n) drive(1'b0, '0, 1'b0, '0, '0);
    endtask

    task automatic bus_write(input logic [1:0] off, input logic [DATA_W-1:0] d);
        drive(1'b1, BASE + ADDR_W'(off), 1'b1, d, '0);
    endtask

    // read data is combinational, stable since the falling edge
    task automatic bus_read(input logic [1:0] off, output logic [DATA_W-1:0] d);
        drive(1'b1, BASE + ADDR_W'(off), 1'b0, '0, '0);
        @(posedge clk);
        d = data_out;
    endtask

    task automatic fire_pulse(input int_src_t p);
        drive(1'b0, '0, 1'b0, '0, p);
    endtask

    // poll status until all mask bits are set
    task automatic wait_status(input int_src_t mask);
        logic [DATA_W-1:0] rd;
        int tries;
        rd = '0;
        tries = 0;
        while (((rd[3:0] & mask) != mask) && (tries < WAIT_LIMIT)) begin
            bus_read(REG_STATUS, rd);
            tries++;
        end
        if ((rd[3:0] & mask) != mask) begin
            $display("timeout: status bits %b not set within %0d cycles", mask, WAIT_LIMIT);
            timeouts++;
        end
    endtask

    // checker errors, wait timeouts and assertion failures
    function automatic int fail_total();
        return err_count + timeouts + i_dut.i_sva.reset_fails
            + i_dut.i_sva.status_fails + i_dut.i_sva.window_fails;
    endfunction

    task automatic start_test(input logic [3:0] n, input string name);
        test_num     = n;
        label        = name;
        fails_before = fail_total();
    endtask

    // let the last access get checked before counting
    task automatic end_test();
        idle(1);
        @(posedge clk);
        #1;
        $display("test %0d %s: %0d errors", test_num, label, fail_total() - fails_before);
    endtask

    initial begin
        logic [DATA_W-1:0] v;
        logic [DATA_W-1:0] rd;
        rst          = 1'b1;
        enable       = 1'b0;
        addr         = '0;
        req          = '0;
        int_in       = '0;
        test_num     = '0;
        timeouts     = 0;
        fails_before = 0;
        lfsr         = 32'hd346;
        label        = "none";
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;

        start_test(4'd1, "reset_values");
        idle(2);
        bus_read(REG_ENABLE, rd);
        bus_read(REG_LEVEL, rd);
        bus_read(REG_STATUS, rd);
        end_test();

        // upper bits of enable and status are dropped on write
        start_test(4'd2, "register_readback");
        repeat (8) begin
            rand_bits(8, v);
            bus_write(REG_ENABLE, v);
            bus_read(REG_ENABLE, rd);
            rand_bits(8, v);
            bus_write(REG_LEVEL, v);
            bus_read(REG_LEVEL, rd);
            rand_bits(8, v);
            bus_write(REG_STATUS, v);
            bus_read(REG_STATUS, rd);
        end
        bus_write(REG_STATUS, 8'h00);
        end_test();

        start_test(4'd3, "sticky_status");
        for (int i = 0; i < NUM_SRC; i++) begin
            fire_pulse(int_src_t'(4'b0001 << i));
            wait_status(int_src_t'(4'b0001 << i));
            // pulse gone, bit must hold
            idle(2);
            bus_read(REG_STATUS, rd);
            bus_write(REG_STATUS, 8'h00);
            bus_read(REG_STATUS, rd);
        end
        // clearing write collides with a new pulse, the pulse wins
        fire_pulse(int_src_t'(4'b0001));
        wait_status(int_src_t'(4'b0001));
        drive(1'b1, BASE + ADDR_W'(REG_STATUS), 1'b1, 8'h00, int_src_t'(4'b0100));
        bus_read(REG_STATUS, rd);
        bus_write(REG_STATUS, 8'h00);
        end_test();

        start_test(4'd4, "interrupt_routing");
        repeat (16) begin
            rand_bits(4, v);
            bus_write(REG_ENABLE, v);
            rand_bits(8, v);
            bus_write(REG_LEVEL, v);
            rand_bits(4, v);
            fire_pulse(int_src_t'(v[3:0]));
            idle(2);
            bus_write(REG_STATUS, 8'h00);
        end
        // everything pending, all masked
        bus_write(REG_ENABLE, 8'h00);
        fire_pulse(int_src_t'(4'hF));
        idle(2);
        // all sources on one shared line
        bus_write(REG_LEVEL, 8'hFF);
        bus_write(REG_ENABLE, 8'h0F);
        idle(2);
        bus_write(REG_STATUS, 8'h00);
        end_test();

        start_test(4'd5, "outside_window");
        bus_write(REG_ENABLE, 8'h05);
        bus_write(REG_LEVEL, 8'hA5);
        // base-1 and base+3 first, then further out so every low offset is tried
        for (int i = 1; i <= 4; i++) begin
            drive(1'b1, BASE - ADDR_W'(i), 1'b1, 8'hFF, '0);
            drive(1'b1, BASE + ADDR_W'(i + 2), 1'b1, 8'hFF, '0);
        end
        // writes inside the window with the strobe low
        for (int i = 0; i < 3; i++) begin
            drive(1'b0, BASE + ADDR_W'(i), 1'b1, 8'hFF, '0);
        end
        for (int i = 1; i <= 4; i++) begin
            drive(1'b1, BASE - ADDR_W'(i), 1'b0, '0, '0);
            drive(1'b1, BASE + ADDR_W'(i + 2), 1'b0, '0, '0);
        end
        // reads inside the window with the strobe low
        for (int i = 0; i < 3; i++) begin
            drive(1'b0, BASE + ADDR_W'(i), 1'b0, '0, '0);
        end
        bus_read(REG_ENABLE, rd);
        bus_read(REG_LEVEL, rd);
        bus_read(REG_STATUS, rd);
        end_test();

        total_fails = fail_total();
        $display("totals: %0d tests, %0d checker errors, %0d timeouts, %0d failures overall",
                 NUM_TESTS, err_count, timeouts, total_fails);
        if (total_fails == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
design/reflet_pkg.sv
design/reflet_rw_register.sv
design/reflet_rwe_register.sv
design/reflet_int_router.sv
design/reflet_exti.sv
sim/reflet_exti_sva.sv
sim/reflet_exti_checker.sv
sim/reflet_exti_tb.sv
